// File: sources.f
logic/bpred_pkg.sv
logic/counter_table.sv
logic/history_tables.sv
logic/target_buffer.sv
logic/perf_counters.sv
logic/branch_predictor.sv
tb/bpred_model.sv
tb/tb_branch_predictor.sv

// File: tb/tb_branch_predictor.sv
module tb_branch_predictor
import bpred_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_CYCLES     = 1500;
    localparam int QUIET_CYCLES   = 24;   // lookups only while the btb is empty
    localparam int TIMEOUT_CYCLES = NUM_CYCLES + NUM_CYCLES / 3;

    logic         clk;
    logic         reset;
    word_t        lookup_pc;
    prediction_t  prediction;
    logic         resolve_valid;
    resolve_t     resolve;
    perf_counts_t counts;

    int unsigned  error_count;
    int unsigned  check_count;
    int unsigned  cycle_count;
    resolve_t     pending [$];            // earlier lookups waiting to resolve
    word_t        targets [4] = '{32'h0000_1040, 32'h0000_2011, 32'h0000_3000, 32'h0000_1025};

    branch_predictor u_dut (
        .clk(clk),
        .reset(reset),
        .lookup_pc(lookup_pc),
        .prediction(prediction),
        .resolve_valid(resolve_valid),
        .resolve(resolve),
        .counts(counts)
    );

    bpred_model u_model ();

    always #20 clk = ~clk;

    task automatic check(string name, logic [63:0] got, logic [63:0] expected);
        check_count++;
        if (got !== expected) begin
            error_count++;
            $display("ERR %s got %h expected %h", name, got, expected);
        end
    endtask

    // 12 slots under each of two tags with colliding indices
    function automatic word_t pool_pc(int unsigned k);
        return (k < 12) ? 32'h0000_1000 + 4 * k : 32'h0000_2000 + 4 * (k - 12);
    endfunction

    task automatic drive_inputs(int cycle);
        resolve_t    r;
        int unsigned roll;
        resolve_valid = 1'b0;
        lookup_pc     = pool_pc($urandom % 24);
        if (cycle >= QUIET_CYCLES && pending.size() > 0 && $urandom % 2 == 0) begin
            r      = pending.pop_front();
            roll   = $urandom % 4;
            r.kind = (roll < 2) ? cf_br : ((roll == 2) ? cf_jal : cf_jalr);
            r.taken = (r.kind != cf_br) || ($urandom % 8 < (r.pc[2] ? 6 : 2));
            r.target      = targets[$urandom % 4];
            resolve       = r;
            resolve_valid = 1'b1;
            if ($urandom % 4 == 0) begin
                lookup_pc = r.pc;  // same-cycle lookup sees the old tables
            end
        end
    endtask

    task automatic check_outputs();
        prediction_t exp_pred;
        resolve_t    entry;
        exp_pred = u_model.predict(lookup_pc);
        check("prediction.taken", prediction.taken, exp_pred.taken);
        check("prediction.btb_hit", prediction.btb_hit, exp_pred.btb_hit);
        check("prediction.target", prediction.target, exp_pred.target);
        check("prediction.kind", prediction.kind, exp_pred.kind);
        check("prediction.local_pred", prediction.local_pred, exp_pred.local_pred);
        check("prediction.global_pred", prediction.global_pred, exp_pred.global_pred);
        check("prediction.global_index", prediction.global_index, exp_pred.global_index);
        check("prediction.local_index", prediction.local_index, exp_pred.local_index);
        check("counts", counts, u_model.snapshot_counts());
        entry      = '0;
        entry.pc   = lookup_pc;
        entry.pred = prediction;
        pending.push_back(entry);
        if (pending.size() > 6) begin
            void'(pending.pop_front());
        end
    endtask

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        void'($urandom(76));
        clk           = 1'b0;
        reset         = 1'b1;
        lookup_pc     = pool_pc(0);
        resolve_valid = 1'b0;
        resolve       = '0;
        error_count   = 0;
        check_count   = 0;
        cycle_count   = 0;
        u_model.reset_state();
        repeat (16) @(posedge clk);
        #2;
        reset = 1'b0;
        for (int cycle = 0; cycle < NUM_CYCLES; cycle++) begin
            drive_inputs(cycle);
            @(negedge clk);
            check_outputs();
            @(posedge clk);
            if (resolve_valid) begin
                u_model.train(resolve);  // dut takes the pulse on this edge
            end
            #2;
        end
        $display("%0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule : tb_branch_predictor

// File: tb/bpred_model.sv
module bpred_model
import bpred_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    history_t    ghr;
    history_t    bht        [16];
    counter_t    global_pht [2**HISTORY_DEPTH];
    counter_t    local_pht  [2**HISTORY_DEPTH];
    counter_t    chooser    [32];
    logic        btb_valid  [16];
    word_t       btb_pc     [16];   // full pc kept for the tag compare
    cf_kind_t    btb_kind   [16];
    word_t       btb_target [16];
    perf_count_t count      [4];    // control_flow, branches, correct, no_stall
    logic        overflow   [4];

    function automatic counter_t saturate_step(counter_t c, logic up);
        return up ? ((c == 2'd3) ? c : c + 2'd1) : ((c == 2'd0) ? c : c - 2'd1);
    endfunction

    function automatic void reset_state();
        ghr = '0;
        for (int i = 0; i < 2**HISTORY_DEPTH; i++) begin
            global_pht[i] = PHT_RESET_VALUE;
            local_pht[i]  = PHT_RESET_VALUE;
        end
        for (int i = 0; i < 32; i++) begin
            chooser[i] = CHOOSER_RESET_VALUE;
        end
        for (int i = 0; i < 16; i++) begin
            bht[i]       = '0;
            btb_valid[i] = 1'b0;
        end
        for (int i = 0; i < 4; i++) begin
            count[i]    = '0;
            overflow[i] = 1'b0;
        end
    endfunction

    function automatic prediction_t predict(word_t pc);
        prediction_t p;
        int unsigned s;
        logic        hit;
        s   = pc[5:2];
        hit = btb_valid[s] && (btb_pc[s][31:6] == pc[31:6]);
        p.btb_hit      = hit;
        p.global_index = ghr;
        p.local_index  = bht[s];
        p.global_pred  = global_pht[ghr][1];
        p.local_pred   = local_pht[bht[s]][1];
        p.kind         = hit ? btb_kind[s] : cf_br;
        if (!hit) begin
            p.taken = 1'b0;
        end else if (btb_kind[s] != cf_br) begin
            p.taken = 1'b1;
        end else begin
            p.taken = (chooser[pc[6:2]] >= 2) ? p.global_pred : p.local_pred;
        end
        p.target = p.taken ? btb_target[s] : pc + 32'd4;
        return p;
    endfunction

    function automatic void train(resolve_t r);
        int unsigned s;
        word_t       clean;
        word_t       actual_next;
        logic        target_hit;
        logic [3:0]  inc;
        s     = r.pc[5:2];
        clean = r.target;
        if (r.kind == cf_jalr) begin
            clean[0] = 1'b0;
        end
        actual_next = r.taken ? clean : r.pc + 32'd4;
        target_hit  = r.pred.btb_hit && (r.pred.target == actual_next);
        inc[0] = 1'b1;
        inc[1] = (r.kind == cf_br);
        inc[2] = inc[1] && (r.taken == r.pred.taken);
        if (r.kind == cf_br) begin
            inc[3] = (target_hit && r.taken == r.pred.taken) || (!r.pred.btb_hit && !r.taken);
        end else begin
            inc[3] = target_hit;
        end
        for (int i = 0; i < 4; i++) begin
            if (inc[i]) begin
                if (count[i] == 8'hff) begin
                    overflow[i] = 1'b1;   // sticky until reset
                end
                count[i] = count[i] + 8'd1;
            end
        end
        btb_valid[s]  = 1'b1;
        btb_pc[s]     = r.pc;
        btb_kind[s]   = r.kind;
        btb_target[s] = clean;
        if (r.kind == cf_br) begin
            global_pht[r.pred.global_index] = saturate_step(global_pht[r.pred.global_index],
                                                            r.taken);
            local_pht[r.pred.local_index]   = saturate_step(local_pht[r.pred.local_index],
                                                            r.taken);
            ghr    = {ghr[HISTORY_DEPTH-2:0], r.taken};
            bht[s] = {bht[s][HISTORY_DEPTH-2:0], r.taken};
            if (r.pred.local_pred != r.pred.global_pred) begin  // chooser learns on disagreement
                chooser[r.pc[6:2]] = saturate_step(chooser[r.pc[6:2]],
                                                   r.pred.global_pred == r.taken);
            end
        end
    endfunction

    function automatic perf_counts_t snapshot_counts();
        perf_counts_t c;
        c.control_flow              = count[0];
        c.control_flow_overflow     = overflow[0];
        c.branches                  = count[1];
        c.branches_overflow         = overflow[1];
        c.correct_branches          = count[2];
        c.correct_branches_overflow = overflow[2];
        c.no_stall_flow             = count[3];
        c.no_stall_flow_overflow    = overflow[3];
        return c;
    endfunction

endmodule : bpred_model

// File: logic/branch_predictor.sv
module branch_predictor
import bpred_pkg::*;
(
    input  logic         clk,
    input  logic         reset,

    input  word_t        lookup_pc,
    output prediction_t  prediction,

    input  logic         resolve_valid,
    input  resolve_t     resolve,

    output perf_counts_t counts
);

    history_t global_history;
    history_t local_history;
    counter_t global_counter;
    counter_t local_counter;
    counter_t chooser_counter;

    logic     btb_hit;
    cf_kind_t btb_kind;
    word_t    btb_target;
    word_t    btb_write_target;

    logic     train_branch;
    logic     pht_up;
    logic     pht_down;
    logic     disagree;
    logic     global_right;
    logic     chooser_up;
    logic     chooser_down;
    logic     predict_taken;

    // pattern and history tables only learn from branches
    assign train_branch = resolve_valid && (resolve.kind == cf_br);
    assign pht_up       = train_branch && resolve.taken;
    assign pht_down     = train_branch && !resolve.taken;

    // chooser moves only when the two predictors disagreed
    assign disagree     = resolve.pred.local_pred != resolve.pred.global_pred;
    assign global_right = resolve.pred.global_pred == resolve.taken;
    assign chooser_up   = train_branch && disagree && global_right;
    assign chooser_down = train_branch && disagree && !global_right;

    assign btb_write_target = (resolve.kind == cf_jalr)
                              ? {resolve.target[XLEN-1:1], 1'b0} : resolve.target;

    history_tables u_history_tables (
        .clk(clk),
        .reset(reset),
        .shift(train_branch),
        .taken(resolve.taken),
        .read_pc(lookup_pc),
        .write_pc(resolve.pc),
        .global_history(global_history),
        .local_history(local_history)
    );

    counter_table #(.INDEX_BITS(HISTORY_DEPTH), .RESET_VALUE(PHT_RESET_VALUE)) u_global_pht (
        .clk(clk),
        .reset(reset),
        .increment(pht_up),
        .decrement(pht_down),
        .read_index(global_history),
        .write_index(resolve.pred.global_index),  // snapshot from lookup time
        .value(global_counter)
    );

    counter_table #(.INDEX_BITS(HISTORY_DEPTH), .RESET_VALUE(PHT_RESET_VALUE)) u_local_pht (
        .clk(clk),
        .reset(reset),
        .increment(pht_up),
        .decrement(pht_down),
        .read_index(local_history),
        .write_index(resolve.pred.local_index),
        .value(local_counter)
    );

    counter_table #(
        .INDEX_BITS(CHOOSER_INDEX_BITS),
        .RESET_VALUE(CHOOSER_RESET_VALUE)
    ) u_chooser (
        .clk(clk),
        .reset(reset),
        .increment(chooser_up),
        .decrement(chooser_down),
        .read_index(lookup_pc[CHOOSER_INDEX_BITS+1:2]),
        .write_index(resolve.pc[CHOOSER_INDEX_BITS+1:2]),
        .value(chooser_counter)
    );

    target_buffer u_target_buffer (
        .clk(clk),
        .reset(reset),
        .write(resolve_valid),
        .read_pc(lookup_pc),
        .write_pc(resolve.pc),
        .write_kind(resolve.kind),
        .write_target(btb_write_target),
        .hit(btb_hit),
        .kind(btb_kind),
        .target(btb_target)
    );

    perf_counters u_perf_counters (
        .clk(clk),
        .reset(reset),
        .resolve_valid(resolve_valid),
        .resolve(resolve),
        .counts(counts)
    );

    always_comb begin
        if (!btb_hit) begin
            predict_taken = 1'b0;
        end else if (btb_kind != cf_br) begin
            predict_taken = 1'b1;                // jumps always redirect
        end else if (chooser_counter[1]) begin
            predict_taken = global_counter[1];   // chooser leans global
        end else begin
            predict_taken = local_counter[1];
        end
    end

    assign prediction.taken        = predict_taken;
    assign prediction.btb_hit      = btb_hit;
    assign prediction.target       = predict_taken ? btb_target : lookup_pc + word_t'(4);
    assign prediction.kind         = btb_kind;
    assign prediction.local_pred   = local_counter[1];
    assign prediction.global_pred  = global_counter[1];
    assign prediction.global_index = global_history;
    assign prediction.local_index  = local_history;

    // decode must hand over a clean record with every pulse
    resolve_kind_known: assert property (
        @(posedge clk) disable iff (reset)
        resolve_valid |-> !$isunknown(resolve.kind)
    ) else $error("branch_predictor: resolve.kind unknown on a resolve pulse");

endmodule : branch_predictor

// File: logic/perf_counters.sv
module perf_counters
import bpred_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         resolve_valid,
    input  resolve_t     resolve,
    output perf_counts_t counts
);

    logic        is_br;
    logic        is_jal;
    logic        is_jalr;
    word_t       clean_target;
    word_t       next_pc;
    logic        target_ok;
    logic        direction_ok;
    logic        no_stall;
    logic [3:0]  enable;      // control_flow, branches, correct, no_stall

    perf_count_t count_q [4];
    logic [3:0]  overflow_q;

    assign is_br   = resolve.kind == cf_br;
    assign is_jal  = resolve.kind == cf_jal;
    assign is_jalr = resolve.kind == cf_jalr;

    assign clean_target = is_jalr ? {resolve.target[XLEN-1:1], 1'b0} : resolve.target;

    // actual next pc to compare with where fetch steered
    assign next_pc      = resolve.taken ? clean_target : resolve.pc + word_t'(4);
    assign target_ok    = resolve.pred.target == next_pc;
    assign direction_ok = resolve.pred.taken == resolve.taken;

    always_comb begin
        no_stall = 1'b0;
        if (is_br) begin
            if (resolve.pred.btb_hit && direction_ok && target_ok) begin
                no_stall = 1'b1;
            end
            if (!resolve.pred.btb_hit && !resolve.taken) begin
                no_stall = 1'b1;  // fell through on pc + 4
            end
        end else if (is_jal || is_jalr) begin
            no_stall = resolve.pred.btb_hit && target_ok;
        end
    end

    assign enable[0] = resolve_valid;
    assign enable[1] = resolve_valid && is_br;
    assign enable[2] = resolve_valid && is_br && direction_ok;
    assign enable[3] = resolve_valid && no_stall;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 4; i++) begin
                count_q[i] <= '0;
            end
            overflow_q <= '0;
        end else begin
            for (int i = 0; i < 4; i++) begin
                if (enable[i]) begin
                    count_q[i] <= count_q[i] + perf_count_t'(1);  // wraps
                    if (count_q[i] == '1) begin
                        overflow_q[i] <= 1'b1;                  // sticky
                    end
                end
            end
        end
    end

    assign counts.control_flow              = count_q[0];
    assign counts.control_flow_overflow     = overflow_q[0];
    assign counts.branches                  = count_q[1];
    assign counts.branches_overflow         = overflow_q[1];
    assign counts.correct_branches          = count_q[2];
    assign counts.correct_branches_overflow = overflow_q[2];
    assign counts.no_stall_flow             = count_q[3];
    assign counts.no_stall_flow_overflow    = overflow_q[3];

endmodule : perf_counters

// File: logic/target_buffer.sv
module target_buffer
import bpred_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     write,
    input  word_t    read_pc,
    input  word_t    write_pc,
    input  cf_kind_t write_kind,
    input  word_t    write_target,
    output logic     hit,
    output cf_kind_t kind,
    output word_t    target
);

    typedef struct packed {
        logic [BTB_TAG_BITS-1:0] tag;
        cf_kind_t                kind;
        word_t                   target;
    } btb_entry_t;

    logic [2**BTB_INDEX_BITS-1:0] valid_q;
    btb_entry_t                   entry_q [2**BTB_INDEX_BITS];

    logic [BTB_INDEX_BITS-1:0] read_index;
    logic [BTB_INDEX_BITS-1:0] write_index;
    btb_entry_t                read_entry;

    assign read_index  = read_pc[BTB_INDEX_BITS+1:2];
    assign write_index = write_pc[BTB_INDEX_BITS+1:2];
    assign read_entry  = entry_q[read_index];

    assign hit    = valid_q[read_index]
                    && (read_entry.tag == read_pc[XLEN-1:BTB_INDEX_BITS+2]);
    assign kind   = hit ? read_entry.kind : cf_br;  // no stale kind on a miss
    assign target = read_entry.target;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= '0;
        end else if (write) begin
            valid_q[write_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (write) begin
            entry_q[write_index] <= '{tag:    write_pc[XLEN-1:BTB_INDEX_BITS+2],
                                      kind:   write_kind,
                                      target: write_target};
        end
    end

    // the parent must clear bit 0 of a jalr target before it gets here
    jalr_target_aligned: assert property (
        @(posedge clk) disable iff (reset)
        (write && write_kind == cf_jalr) |-> !write_target[0]
    ) else $error("target_buffer: jalr target written with bit 0 set");

endmodule : target_buffer

// File: logic/history_tables.sv
module history_tables
import bpred_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     shift,            // branch resolve
    input  logic     taken,
    input  word_t    read_pc,
    input  word_t    write_pc,
    output history_t global_history,
    output history_t local_history
);

    history_t ghr_q;
    history_t bht_q [2**BHT_INDEX_BITS];

    logic [BHT_INDEX_BITS-1:0] read_index;
    logic [BHT_INDEX_BITS-1:0] write_index;

    assign read_index  = read_pc[BHT_INDEX_BITS+1:2];
    assign write_index = write_pc[BHT_INDEX_BITS+1:2];

    assign global_history = ghr_q;
    assign local_history  = bht_q[read_index];

    // newest outcome lands in bit 0
    always_ff @(posedge clk) begin
        if (reset) begin
            ghr_q <= '0;
        end else if (shift) begin
            ghr_q <= {ghr_q[HISTORY_DEPTH-2:0], taken};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 2**BHT_INDEX_BITS; i++) begin
                bht_q[i] <= '0;
            end
        end else if (shift) begin
            bht_q[write_index] <= {bht_q[write_index][HISTORY_DEPTH-2:0], taken};
        end
    end

endmodule : history_tables

// File: logic/counter_table.sv
module counter_table
import bpred_pkg::*;
#(
    parameter int       INDEX_BITS  = HISTORY_DEPTH,
    parameter counter_t RESET_VALUE = PHT_RESET_VALUE
)
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  increment,
    input  logic                  decrement,
    input  logic [INDEX_BITS-1:0] read_index,
    input  logic [INDEX_BITS-1:0] write_index,
    output counter_t              value
);

    counter_t table_q [2**INDEX_BITS];
    counter_t write_entry;

    assign value       = table_q[read_index];  // old contents during a write
    assign write_entry = table_q[write_index];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 2**INDEX_BITS; i++) begin
                table_q[i] <= RESET_VALUE;
            end
        end else if (increment) begin
            if (write_entry != 2'b11) begin  // saturate high
                table_q[write_index] <= write_entry + 2'b01;
            end
        end else if (decrement) begin
            if (write_entry != 2'b00) begin  // saturate low
                table_q[write_index] <= write_entry - 2'b01;
            end
        end
    end

    // strobes are decoded in the parent from one resolved direction
    inc_dec_exclusive: assert property (
        @(posedge clk) disable iff (reset)
        !(increment && decrement)
    ) else $error("counter_table: increment and decrement high together");

endmodule : counter_table

// File: logic/bpred_pkg.sv
package bpred_pkg;

    localparam int XLEN               = 32;
    localparam int HISTORY_DEPTH      = 6;    // global and local history length
    localparam int BHT_INDEX_BITS     = 4;    // pc[5:2]
    localparam int CHOOSER_INDEX_BITS = 5;    // pc[6:2]
    localparam int BTB_INDEX_BITS     = 4;    // pc[5:2]
    localparam int BTB_TAG_BITS       = XLEN - BTB_INDEX_BITS - 2;
    localparam int PERF_COUNTER_WIDTH = 8;    // small so the counters wrap

    localparam logic [1:0] PHT_RESET_VALUE     = 2'b01;  // weakly not taken
    localparam logic [1:0] CHOOSER_RESET_VALUE = 2'b01;  // weakly local

    typedef logic [XLEN-1:0]               word_t;
    typedef logic [HISTORY_DEPTH-1:0]      history_t;
    typedef logic [1:0]                    counter_t;
    typedef logic [PERF_COUNTER_WIDTH-1:0] perf_count_t;

    typedef enum logic [1:0] {
        cf_br,
        cf_jal,
        cf_jalr
    } cf_kind_t;

    // fetch-side answer carried down the pipe to the resolve
    typedef struct packed {
        logic     taken;
        logic     btb_hit;
        word_t    target;        // predicted next pc
        cf_kind_t kind;
        logic     local_pred;
        logic     global_pred;
        history_t global_index;  // ghr snapshot
        history_t local_index;   // bht entry snapshot
    } prediction_t;

    typedef struct packed {
        word_t       pc;
        cf_kind_t    kind;
        logic        taken;      // actual direction
        word_t       target;     // raw target before the jalr bit 0 clear
        prediction_t pred;
    } resolve_t;

    typedef struct packed {
        perf_count_t control_flow;
        logic        control_flow_overflow;
        perf_count_t branches;
        logic        branches_overflow;
        perf_count_t correct_branches;
        logic        correct_branches_overflow;
        perf_count_t no_stall_flow;
        logic        no_stall_flow_overflow;
    } perf_counts_t;

endpackage : bpred_pkg
